//--- logic/lc3b_types.sv
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;  // n, z, p.

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    localparam int          num_regs    = 8;
    localparam lc3b_nzp     cc_zero     = 3'b010;
    localparam logic [1:0]  addr2_off6  = 2'b01;
    localparam logic [1:0]  addr2_off9  = 2'b10;
    localparam logic [1:0]  drmux_adder = 2'b01;
    localparam logic [1:0]  drmux_alu   = 2'b11;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        logic       load_cc;
        logic       load_regfile;
        logic       sr2mux_sel;    // immediate operand.
        logic [1:0] addr2mux_sel;
        logic [1:0] drmux_sel;
        logic       mem_write;
    } lc3b_control_word;

    typedef struct packed {
        logic     valid;
        lc3b_word pc;
        lc3b_word ir;
    } instr_in_t;

    typedef struct packed {
        logic     valid;
        lc3b_reg  dest;
        lc3b_word data;
    } wb_out_t;

    typedef struct packed {
        logic     valid;
        lc3b_word addr;
        lc3b_word data;
    } store_out_t;

endpackage

//--- logic/control_rom.sv
`timescale 1ns/1ns

module control_rom (
    input  lc3b_types::lc3b_opcode       opcode,
    input  logic                         imm_check,   // also picks sra over srl.
    input  logic                         jsr_check,
    input  logic                         rshf_check,
    output lc3b_types::lc3b_control_word ctrl
);
    import lc3b_types::*;

    always_comb begin
        ////////////////////////////////////////////////////////////
        // defaults
        ////////////////////////////////////////////////////////////
        ctrl.opcode       = opcode;
        ctrl.aluop        = alu_pass;
        ctrl.load_cc      = 1'b0;
        ctrl.load_regfile = 1'b0;
        ctrl.sr2mux_sel   = 1'b0;
        ctrl.addr2mux_sel = 2'b00;
        ctrl.drmux_sel    = 2'b00;
        ctrl.mem_write    = 1'b0;

        ////////////////////////////////////////////////////////////
        // per opcode
        ////////////////////////////////////////////////////////////
        case (opcode)
            op_add: begin
                ctrl.aluop        = alu_add;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.drmux_sel    = drmux_alu;
                ctrl.sr2mux_sel   = imm_check;  // imm5 or sr2.
            end

            op_and: begin
                ctrl.aluop        = alu_and;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.drmux_sel    = drmux_alu;
                ctrl.sr2mux_sel   = imm_check;
            end

            op_not: begin
                ctrl.aluop        = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.drmux_sel    = drmux_alu;
            end

            op_shf: begin
                if (!rshf_check) begin
                    ctrl.aluop = alu_sll;
                end else if (!imm_check) begin
                    ctrl.aluop = alu_srl;
                end else begin
                    ctrl.aluop = alu_sra;
                end
                // amount rides in the low bits of the immediate.
                ctrl.sr2mux_sel   = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.drmux_sel    = drmux_alu;
            end

            op_lea: begin
                ctrl.addr2mux_sel = addr2_off9;
                ctrl.drmux_sel    = drmux_adder;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end

            op_str: begin
                ctrl.mem_write    = 1'b1;
                ctrl.addr2mux_sel = addr2_off6;  // base + off6.
            end

            op_jsr: begin
                ctrl = '0;
                if (jsr_check) begin  // pc relative jsr.
                end else begin        // jsrr through a base register.
                end
            end

            default: begin
                ctrl = '0;  // no path here.
            end
        endcase
    end

endmodule

//--- logic/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 we,
    input  lc3b_types::lc3b_reg  wdest,
    input  lc3b_types::lc3b_word wdata,
    input  lc3b_types::lc3b_reg  sr1,
    input  lc3b_types::lc3b_reg  sr2,
    output lc3b_types::lc3b_word sr1_data,
    output lc3b_types::lc3b_word sr2_data
);
    import lc3b_types::*;

    lc3b_word regs [num_regs];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wdest] <= wdata;
        end
    end

    // reads return the stored value.
    assign sr1_data = regs[sr1];
    assign sr2_data = regs[sr2];

endmodule

//--- logic/alu.sv
`timescale 1ns/1ns

module alu (
    input  lc3b_types::lc3b_aluop aluop,
    input  lc3b_types::lc3b_word  a,
    input  lc3b_types::lc3b_word  b,
    output lc3b_types::lc3b_word  f
);
    import lc3b_types::*;

    logic [3:0] shamt;

    assign shamt = b[3:0];

    always_comb begin
        case (aluop)
            alu_add:  f = a + b;
            alu_and:  f = a & b;
            alu_not:  f = ~a;
            alu_pass: f = a;
            alu_sll:  f = a << shamt;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = lc3b_word'($signed(a) >>> shamt);  // sign fill.
            default:  f = a;
        endcase
    end

endmodule

//--- logic/datapath.sv
`timescale 1ns/1ns

module datapath (
    input  logic                         clk,
    input  logic                         rst_n,
    input  lc3b_types::instr_in_t        instr,
    input  lc3b_types::lc3b_control_word ctrl,
    input  lc3b_types::lc3b_word         sr1_data,
    input  lc3b_types::lc3b_word         sr2_data,
    input  lc3b_types::lc3b_word         alu_f,
    output lc3b_types::lc3b_aluop        aluop,
    output lc3b_types::lc3b_word         alu_a,
    output lc3b_types::lc3b_word         alu_b,
    output logic                         rf_we,
    output lc3b_types::lc3b_reg          rf_dest,
    output lc3b_types::lc3b_word         rf_data,
    output lc3b_types::wb_out_t          wb,
    output lc3b_types::store_out_t       store,
    output lc3b_types::lc3b_nzp          cc
);
    import lc3b_types::*;

    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_word         pc;
        lc3b_word         ir;
        lc3b_word         sr1;
        lc3b_word         sr2;
    } ex_reg_t;

    logic     ex_valid;
    ex_reg_t  ex;
    lc3b_reg  id_sr1;
    lc3b_reg  id_sr2;
    lc3b_word sr1_fwd;
    lc3b_word sr2_fwd;
    lc3b_word addr_base;
    lc3b_word addr_off;
    lc3b_word addr_sum;
    lc3b_nzp  cc_next;

    ////////////////////////////////////////////////////////////
    // decode side and bypass from the instruction one ahead
    ////////////////////////////////////////////////////////////
    assign id_sr1  = instr.ir[8:6];
    assign id_sr2  = ctrl.mem_write ? instr.ir[11:9] : instr.ir[2:0];  // str reads sr.
    assign sr1_fwd = (rf_we && rf_dest == id_sr1) ? rf_data : sr1_data;
    assign sr2_fwd = (rf_we && rf_dest == id_sr2) ? rf_data : sr2_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= instr.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex.ctrl <= ctrl;
        ex.pc   <= instr.pc;
        ex.ir   <= instr.ir;
        ex.sr1  <= sr1_fwd;
        ex.sr2  <= sr2_fwd;
    end

    ////////////////////////////////////////////////////////////
    // execute
    ////////////////////////////////////////////////////////////
    assign aluop = ex.ctrl.aluop;
    assign alu_a = ex.sr1;
    assign alu_b = ex.ctrl.sr2mux_sel ? {{11{ex.ir[4]}}, ex.ir[4:0]} : ex.sr2;

    always_comb begin
        case (ex.ctrl.addr2mux_sel)
            addr2_off6: begin
                addr_base = ex.sr1;
                addr_off  = {{9{ex.ir[5]}}, ex.ir[5:0], 1'b0};
            end
            addr2_off9: begin
                addr_base = ex.pc + 16'd2;  // pc already past this word.
                addr_off  = {{6{ex.ir[8]}}, ex.ir[8:0], 1'b0};
            end
            default: begin
                addr_base = ex.pc + 16'd2;
                addr_off  = '0;
            end
        endcase
    end

    assign addr_sum = addr_base + addr_off;

    always_comb begin
        case (ex.ctrl.drmux_sel)
            drmux_alu:   rf_data = alu_f;
            drmux_adder: rf_data = addr_sum;
            default:     rf_data = '0;
        endcase
    end

    assign rf_we   = ex_valid && ex.ctrl.load_regfile;
    assign rf_dest = ex.ir[11:9];
    assign cc_next = rf_data[15] ? 3'b100 : (rf_data == '0) ? 3'b010 : 3'b001;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb    <= '0;
            store <= '0;
            cc    <= cc_zero;
        end else begin
            wb.valid    <= rf_we;
            wb.dest     <= rf_dest;
            wb.data     <= rf_data;
            store.valid <= ex_valid && ex.ctrl.mem_write;
            store.addr  <= addr_sum;
            store.data  <= ex.sr2;  // bypassed store source.
            if (ex_valid && ex.ctrl.load_cc) begin
                cc <= cc_next;
            end
        end
    end

endmodule

//--- logic/lc3b_core.sv
`timescale 1ns/1ns

module lc3b_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  lc3b_types::instr_in_t  instr,
    output lc3b_types::wb_out_t    wb,
    output lc3b_types::store_out_t store,
    output lc3b_types::lc3b_nzp    cc
);
    import lc3b_types::*;

    lc3b_control_word ctrl;
    lc3b_reg          sr2_idx;
    lc3b_word         sr1_data;
    lc3b_word         sr2_data;
    lc3b_aluop        aluop;
    lc3b_word         alu_a;
    lc3b_word         alu_b;
    lc3b_word         alu_f;
    logic             rf_we;
    lc3b_reg          rf_dest;
    lc3b_word         rf_data;

    control_rom u_rom (
        .opcode     (lc3b_opcode'(instr.ir[15:12])),
        .imm_check  (instr.ir[5]),
        .jsr_check  (instr.ir[11]),
        .rshf_check (instr.ir[4]),
        .ctrl       (ctrl)
    );

    assign sr2_idx = ctrl.mem_write ? instr.ir[11:9] : instr.ir[2:0];  // str data reg.

    regfile u_rf (
        .clk      (clk),
        .rst_n    (rst_n),
        .we       (rf_we),
        .wdest    (rf_dest),
        .wdata    (rf_data),
        .sr1      (instr.ir[8:6]),
        .sr2      (sr2_idx),
        .sr1_data (sr1_data),
        .sr2_data (sr2_data)
    );

    alu u_alu (
        .aluop (aluop),
        .a     (alu_a),
        .b     (alu_b),
        .f     (alu_f)
    );

    datapath u_dp (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .ctrl     (ctrl),
        .sr1_data (sr1_data),
        .sr2_data (sr2_data),
        .alu_f    (alu_f),
        .aluop    (aluop),
        .alu_a    (alu_a),
        .alu_b    (alu_b),
        .rf_we    (rf_we),
        .rf_dest  (rf_dest),
        .rf_data  (rf_data),
        .wb       (wb),
        .store    (store),
        .cc       (cc)
    );

endmodule

//--- testbench/core_chk.sv
`timescale 1ns/1ns

module core_chk (
    input logic                   clk,
    input logic                   rst_n,
    input lc3b_types::instr_in_t  instr,
    input lc3b_types::wb_out_t    wb,
    input lc3b_types::store_out_t store,
    input lc3b_types::lc3b_nzp    cc
);
    import lc3b_types::*;

    int         excl_fails = 0;
    int         cc_fails = 0;
    int         strobe_fails = 0;
    int         fail_count;
    lc3b_opcode op;
    logic       in_scope;

    assign op         = lc3b_opcode'(instr.ir[15:12]);
    assign in_scope   = op inside {op_add, op_and, op_not, op_shf, op_lea, op_str};
    assign fail_count = excl_fails + cc_fails + strobe_fails;

    strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb.valid && store.valid))
    else begin
        excl_fails = excl_fails + 1;
        $error("wb and store strobes high in the same cycle");
    end

    // cc moves only with a register write.
    cc_one_hot_and_held: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(cc) && (wb.valid || $stable(cc)))
    else begin
        cc_fails = cc_fails + 1;
        $error("condition codes not one-hot or changed without a writeback");
    end

    // fixed two cycle latency.
    one_strobe_per_instr: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(instr.valid, 2) && $past(in_scope, 2)) |-> (wb.valid ^ store.valid))
    else begin
        strobe_fails = strobe_fails + 1;
        $error("instruction two cycles back did not give exactly one strobe");
    end

endmodule

bind lc3b_core core_chk u_chk (
    .clk   (clk),
    .rst_n (rst_n),
    .instr (instr),
    .wb    (wb),
    .store (store),
    .cc    (cc)
);

//--- testbench/core_monitor.sv
`timescale 1ns/1ns

module core_monitor (
    input  logic                   clk,
    input  logic                   rst_n,
    input  lc3b_types::instr_in_t  instr,
    input  lc3b_types::wb_out_t    wb,
    input  lc3b_types::store_out_t store,
    input  lc3b_types::lc3b_nzp    cc,
    output int                     error_count,
    output int                     pending
);
    import lc3b_types::*;

    typedef struct packed {
        logic [31:0] due;
        lc3b_word    ir;
        wb_out_t     wb;
        store_out_t  store;
        lc3b_nzp     cc;
    } expect_t;

    lc3b_word    regs [num_regs];
    lc3b_nzp     model_cc = 3'b010;
    lc3b_nzp     retired_cc = 3'b010;
    logic [31:0] cycle = '0;
    expect_t     exp_q [$];
    expect_t     cur;
    logic        now_due;

    function automatic lc3b_word sign_extend(input lc3b_word value, input int bits);
        lc3b_word result;
        result = value;
        for (int i = bits; i < 16; i++) begin
            result[i] = value[bits - 1];
        end
        return result;
    endfunction

    function automatic lc3b_word shift_right_fill(input lc3b_word value,
                                                  input logic [3:0] amount,
                                                  input logic arith);
        lc3b_word result;
        logic     fill;
        result = value;
        fill   = arith & value[15];
        for (int i = 0; i < int'(amount); i++) begin
            result = {fill, result[15:1]};
        end
        return result;
    endfunction

    function automatic lc3b_nzp nzp_of(input lc3b_word value);
        if (value[15]) begin
            return 3'b100;
        end else if (value == 16'd0) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    ////////////////////////////////////////////////////////////
    // architectural model, one instruction at a time
    ////////////////////////////////////////////////////////////
    task automatic run_model(input instr_in_t in, output expect_t e);
        lc3b_word ir;
        lc3b_word a;
        lc3b_word b;
        lc3b_word res;
        logic     writes;
        ir     = in.ir;
        a      = regs[ir[8:6]];
        b      = ir[5] ? sign_extend(ir, 5) : regs[ir[2:0]];
        res    = '0;
        writes = 1'b1;
        e      = '0;
        e.ir   = ir;
        case (lc3b_opcode'(ir[15:12]))
            op_add: res = a + b;
            op_and: res = a & b;
            op_not: res = ~a;
            op_shf: begin
                if (!ir[4]) begin
                    res = a << ir[3:0];
                end else begin
                    res = shift_right_fill(a, ir[3:0], ir[5]);
                end
            end
            op_lea: res = in.pc + 16'd2 + (sign_extend(ir, 9) << 1);
            op_str: begin
                writes        = 1'b0;
                e.store.valid = 1'b1;
                e.store.addr  = a + (sign_extend(ir, 6) << 1);
                e.store.data  = regs[ir[11:9]];
            end
            default: writes = 1'b0;  // no effect in this slice.
        endcase
        if (writes) begin
            regs[ir[11:9]] = res;
            model_cc       = nzp_of(res);
            e.wb.valid     = 1'b1;
            e.wb.dest      = ir[11:9];
            e.wb.data      = res;
        end
        e.cc = model_cc;
    endtask

    task automatic compare_outputs(input expect_t e);
        if (e.wb.valid !== wb.valid) begin
            $display("wb strobe %s at cycle %0d (ir %h)",
                     wb.valid ? "unexpected" : "missing", cycle, e.ir);
            error_count++;
        end else if (wb.valid) begin
            if (wb.dest !== e.wb.dest) begin
                $display("mismatch wb.dest: expected %h, got %h", e.wb.dest, wb.dest);
                error_count++;
            end
            if (wb.data !== e.wb.data) begin
                $display("mismatch wb.data: expected %h, got %h", e.wb.data, wb.data);
                error_count++;
            end
        end
        if (e.store.valid !== store.valid) begin
            $display("store strobe %s at cycle %0d (ir %h)",
                     store.valid ? "unexpected" : "missing", cycle, e.ir);
            error_count++;
        end else if (store.valid) begin
            if (store.addr !== e.store.addr) begin
                $display("mismatch store.addr: expected %h, got %h", e.store.addr, store.addr);
                error_count++;
            end
            if (store.data !== e.store.data) begin
                $display("mismatch store.data: expected %h, got %h", e.store.data, store.data);
                error_count++;
            end
        end
        if (cc !== e.cc) begin
            $display("mismatch cc: expected %h, got %h", e.cc, cc);
            error_count++;
        end
    endtask

    // inputs at the rising edge, outputs at the falling edge.
    initial begin
        error_count = 0;
        pending     = 0;
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                for (int i = 0; i < num_regs; i++) begin
                    regs[i] = '0;
                end
                model_cc   = cc_zero;
                retired_cc = cc_zero;
                cycle      = '0;
                exp_q.delete();
            end else begin
                cycle = cycle + 32'd1;
                if (instr.valid) begin
                    run_model(instr, cur);
                    cur.due = cycle + 32'd1;
                    exp_q.push_back(cur);
                end
            end

            @(negedge clk);
            now_due = 1'b0;
            if (exp_q.size() > 0) begin
                if (exp_q[0].due == cycle) begin
                    now_due = 1'b1;
                end
            end
            if (now_due) begin
                cur        = exp_q.pop_front();
                retired_cc = cur.cc;
            end else begin
                cur    = '0;  // nothing may move while idle.
                cur.cc = retired_cc;
            end
            compare_outputs(cur);
            pending = exp_q.size();
        end
    end

endmodule

//--- testbench/core_tb.sv
`timescale 1ns/1ns

module core_tb;
    import lc3b_types::*;

    localparam int num_instr  = 600;
    localparam int max_gaps   = num_instr / 4;
    localparam int max_cycles = num_instr + max_gaps + 50;

    logic        clk = 1'b0;
    logic        rst_n;
    instr_in_t   instr;
    wb_out_t     wb;
    store_out_t  store;
    lc3b_nzp     cc;
    int          mon_errors;
    int          mon_pending;
    int          total_errors;
    int          cycles = 0;
    int          sent;
    int          gaps;
    logic [31:0] lcg_state;
    logic [15:0] r;

    lc3b_core uut (
        .clk   (clk),
        .rst_n (rst_n),
        .instr (instr),
        .wb    (wb),
        .store (store),
        .cc    (cc)
    );

    core_monitor mon (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .wb          (wb),
        .store       (store),
        .cc          (cc),
        .error_count (mon_errors),
        .pending     (mon_pending)
    );

    always #5 clk = ~clk;

    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // mostly in-scope opcodes plus a few the slice ignores.
    function automatic lc3b_word make_ir();
        logic [15:0] sel;
        logic [15:0] body;
        int          pick;
        lc3b_opcode  op;
        sel  = next_random();
        body = next_random();
        pick = int'(sel[15:8]) % 20;
        case (pick)
            0, 1, 2, 3:   op = op_add;
            4, 5, 6:      op = op_and;
            7, 8:         op = op_not;
            9, 10, 11, 12: op = op_shf;
            13, 14:       op = op_lea;
            15, 16, 17:   op = op_str;
            default: begin
                case (sel[2:0])
                    3'd0:    op = op_br;
                    3'd1:    op = op_ldb;
                    3'd2:    op = op_stb;
                    3'd3:    op = op_jsr;
                    3'd4:    op = op_ldr;
                    3'd5:    op = op_ldi;
                    3'd6:    op = op_jmp;
                    default: op = op_trap;
                endcase
            end
        endcase
        return {op, body[11:0]};
    endfunction

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        rst_n     = 1'b0;
        instr     = '0;
        lcg_state = 32'd67;
        sent      = 0;
        gaps      = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        while (sent < num_instr) begin
            @(negedge clk);
            r = next_random();
            if (gaps < max_gaps && r[2:0] == 3'd0) begin
                instr.valid = 1'b0;
                gaps++;
            end else begin
                r           = next_random();
                instr.pc    = {r[15:1], 1'b0};
                instr.ir    = make_ir();
                instr.valid = 1'b1;
                sent++;
            end
        end
        @(negedge clk);
        instr.valid = 1'b0;
        repeat (4) @(negedge clk);  // drain the pipeline.

        total_errors = mon_errors + uut.u_chk.fail_count;
        if (mon_pending != 0) begin
            $display("%0d instructions never produced their result", mon_pending);
            total_errors++;
        end
        $display("errors: %0d (monitor %0d, assertions %0d, instructions %0d, gaps %0d)",
                 total_errors, mon_errors, uut.u_chk.fail_count, sent, gaps);
        if (total_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
logic/lc3b_types.sv
logic/control_rom.sv
logic/regfile.sv
logic/alu.sv
logic/datapath.sv
logic/lc3b_core.sv
testbench/core_chk.sv
testbench/core_monitor.sv
testbench/core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module core_tb -f src.f -o core_sim

# error limit keeps assertion failures from stopping the run before the report
./obj_dir/core_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q '^>>> PASS$' sim.log; then
    exit 0
fi
exit 1
